// File: spi_cmd_defs.svh
`ifndef SPI_CMD_DEFS_SVH
`define SPI_CMD_DEFS_SVH

`define SPI_CMD_W      12 // rw, 3-bit address, 8-bit data.
`define SPI_READ_W     8
`define SPI_HALF_DIV   4  // clk cycles per sclk half period.
`define SPI_FIFO_DEPTH 4

// sclk must spend at least two clk cycles in each level.

`endif

// File: spi_cmd_pkg.sv
`include "spi_cmd_defs.svh"

package spi_cmd_pkg;

  typedef logic [`SPI_CMD_W-1:0]  cmd_t;   // [11] rw, [10:8] addr, [7:0] wdata.
  typedef logic [`SPI_READ_W-1:0] rdata_t;
  typedef logic [3:0]             bit_cnt_t;

  typedef enum logic [2:0]
  {
    IDLE,
    LEAD,      // cs low, sclk still parked.
    SHIFT_OUT,
    SHIFT_IN,
    TRAIL
  } xfer_state_t;

endpackage

// File: spi_cmd_fifo.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_cmd_fifo
  import spi_cmd_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  cmd_t cmd_in,
  input  logic cmd_vld,
  output logic cmd_rdy,
  input  logic q_pop,
  output cmd_t q_data,
  output logic q_empty
);

  localparam int DEPTH = `SPI_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  cmd_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_LAST)
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign cmd_rdy = (count != CNT_FULL);
  assign q_empty = (count == '0);
  assign q_data  = mem[rd_ptr]; // oldest entry, shown without a read cycle.

  assign push = cmd_vld && cmd_rdy;
  assign pop  = q_pop && !q_empty;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // push and pop together keep the level.
      endcase
    end
  end

  // the host only strobes while there is room.
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_vld |-> cmd_rdy
  );

  // the controller only pops a real entry.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    q_pop |-> !q_empty
  );

endmodule

// File: spi_sclk_gen.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  localparam int CNT_W = (`SPI_HALF_DIV > 1) ? $clog2(`SPI_HALF_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPI_HALF_DIV - 1);

  logic [CNT_W-1:0] half_cnt;
  logic             half_done;

  assign half_done = (half_cnt == CNT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt  <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!sclk_en)
    begin
      half_cnt  <= '0;
      sclk      <= 1'b0; // park low between transfers.
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      sclk_rise <= half_done && !sclk; // strobes line up with the new sclk level.
      sclk_fall <= half_done && sclk;
      if (half_done)
      begin
        half_cnt <= '0;
        sclk     <= ~sclk;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  a_sclk_parked: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$past(sclk_en) |-> !sclk
  );

endmodule

// File: spi_xfer_ctrl.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_xfer_ctrl
  import spi_cmd_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  cmd_t   q_data,
  input  logic   q_empty,
  output logic   q_pop,
  input  logic   sclk_rise,
  input  logic   sclk_fall,
  output logic   sclk_en,
  output logic   cs,
  output logic   mosi,
  input  logic   miso,
  output logic   read_vld,
  output rdata_t read_data
);

  localparam int CMD_MSB = `SPI_CMD_W - 1;
  localparam int HDR_W   = `SPI_CMD_W - `SPI_READ_W; // rw plus address.
  localparam int TMR_W   = $clog2(2 * `SPI_HALF_DIV);

  localparam logic [TMR_W-1:0] TMR_ONE   = TMR_W'(1);
  localparam logic [TMR_W-1:0] HALF_LAST = TMR_W'(`SPI_HALF_DIV - 1);
  localparam logic [TMR_W-1:0] GAP_LAST  = TMR_W'(2 * `SPI_HALF_DIV - 1);
  localparam bit_cnt_t         BIT_LAST  = bit_cnt_t'(`SPI_CMD_W - 1);
  localparam bit_cnt_t         HDR_LAST  = bit_cnt_t'(HDR_W - 1);

  xfer_state_t      state;
  xfer_state_t      state_nxt;
  logic [TMR_W-1:0] tmr;
  bit_cnt_t         bit_cnt;
  logic             rw_q;
  logic             last_fall;
  logic             hdr_fall;
  cmd_t             tx_sr;
  rdata_t           rx_sr;

  assign last_fall = sclk_fall && (bit_cnt == BIT_LAST);
  assign hdr_fall  = sclk_fall && (bit_cnt == HDR_LAST);

  // a new command is taken only after cs has been high for a full period.
  assign q_pop   = (state == IDLE) && !q_empty && (tmr == GAP_LAST);
  assign sclk_en = (state == SHIFT_OUT) || (state == SHIFT_IN);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (q_pop)
          state_nxt = LEAD;
      end
      LEAD:
      begin
        if (tmr == HALF_LAST)
          state_nxt = SHIFT_OUT;
      end
      SHIFT_OUT:
      begin
        if (last_fall)
          state_nxt = TRAIL;
        else if (hdr_fall && !rw_q)
          state_nxt = SHIFT_IN; // read turns around after the header.
      end
      SHIFT_IN:
      begin
        if (last_fall)
          state_nxt = TRAIL;
      end
      TRAIL:
      begin
        if (tmr == HALF_LAST)
          state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      tmr      <= '0;
      bit_cnt  <= '0;
      rw_q     <= 1'b0;
      cs       <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      read_vld <= 1'b0;

      // the twelfth fall cycle already counts as the first trail cycle.
      if (state_nxt != state)
        tmr <= (state_nxt == TRAIL) ? TMR_ONE : '0;
      else if (tmr != GAP_LAST)
        tmr <= tmr + 1'b1;

      case (state)
        IDLE:
        begin
          if (q_pop)
          begin
            cs      <= 1'b0;
            mosi    <= q_data[CMD_MSB]; // first bit is up before the lead half period.
            rw_q    <= q_data[CMD_MSB];
            bit_cnt <= '0;
          end
        end
        SHIFT_OUT, SHIFT_IN:
        begin
          if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (state == SHIFT_OUT && state_nxt == SHIFT_OUT)
              mosi <= tx_sr[CMD_MSB-1];
            else
              mosi <= 1'b0;
          end
        end
        TRAIL:
        begin
          if (state_nxt == IDLE)
          begin
            cs       <= 1'b1;
            read_vld <= !rw_q;
          end
        end
        default:
        begin
          cs <= cs;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (q_pop)
      tx_sr <= q_data;
    else if (state == SHIFT_OUT && sclk_fall)
      tx_sr <= {tx_sr[CMD_MSB-1:0], 1'b0};

    if (state == SHIFT_IN && sclk_rise)
      rx_sr <= {rx_sr[`SPI_READ_W-2:0], miso}; // msb first.

    if (state == TRAIL && state_nxt == IDLE && !rw_q)
      read_data <= rx_sr;
  end

  a_read_vld_on_cs_rise: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> cs && !$past(cs)
  );

  a_sclk_only_selected: assert property (
    @(posedge clk) disable iff (!rst_n)
    sclk_en |-> !cs
  );

  // mosi may only move on the cycle after a fall.
  a_mosi_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!cs && !$past(cs) && !$past(sclk_fall)) |-> $stable(mosi)
  );

endmodule

// File: spi_cmd_top.sv
`timescale 1ns/1ps

module spi_cmd_top
  import spi_cmd_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  cmd_t   cmd_in,
  input  logic   cmd_vld,
  output logic   cmd_rdy,
  output logic   sclk,
  output logic   cs,
  output logic   mosi,
  input  logic   miso,
  output logic   read_vld,
  output rdata_t read_data
);

  cmd_t q_data;
  logic q_empty;
  logic q_pop;
  logic sclk_en;
  logic sclk_rise;
  logic sclk_fall;

  spi_cmd_fifo fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .q_pop   (q_pop),
    .q_data  (q_data),
    .q_empty (q_empty)
  );

  spi_xfer_ctrl ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_data    (q_data),
    .q_empty   (q_empty),
    .q_pop     (q_pop),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .sclk_en   (sclk_en),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_sclk_gen sclk_gen_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

endmodule

// File: spi_slave_model.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_slave_model
  import spi_cmd_pkg::*;
(
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  rdata_t     regs [8]; // register file, read by the testbench by hierarchy.
  cmd_t       rx_sr;
  bit_cnt_t   bit_cnt;
  logic [2:0] rd_addr;
  logic       rd_active;

  initial
  begin
    miso      = 1'b0;
    rx_sr     = '0;
    bit_cnt   = '0;
    rd_addr   = '0;
    rd_active = 1'b0;
    for (int i = 0; i < 8; i++)
      regs[i] = 8'h3c ^ (8'(i) * 8'h25); // pattern over the whole address.
  end

  // sclk is parked low at the falling cs, so a low sclk marks a new frame.
  always @(posedge sclk or negedge cs)
  begin
    if (!sclk)
    begin
      bit_cnt <= '0;
    end
    else if (!cs)
    begin
      rx_sr   <= {rx_sr[`SPI_CMD_W-2:0], mosi}; // msb first.
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always @(negedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if (bit_cnt == bit_cnt_t'(`SPI_CMD_W) && rx_sr[`SPI_CMD_W-1])
        regs[rx_sr[10:8]] <= rx_sr[7:0]; // complete write frame.
      rd_active <= 1'b0;
      miso      <= 1'b0;
    end
    else if (bit_cnt == 4'd4)
    begin
      // header is in, the read turns around here.
      rd_active <= !rx_sr[3];
      rd_addr   <= rx_sr[2:0];
      miso      <= !rx_sr[3] && regs[rx_sr[2:0]][7];
    end
    else if (rd_active && bit_cnt < bit_cnt_t'(`SPI_CMD_W))
    begin
      miso <= regs[rd_addr][11 - bit_cnt];
    end
  end

endmodule

// File: tb_spi_cmd_top.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module tb_spi_cmd_top
  import spi_cmd_pkg::*;
();

  localparam int XFER_CYCLES = 26 * `SPI_HALF_DIV;
  localparam int GAP_CYCLES  = 2 * `SPI_HALF_DIV;
  localparam int MAX_CYCLES  = 40 * 30 * `SPI_HALF_DIV + 500;

  logic   clk;
  logic   rst_n;
  cmd_t   cmd_in;
  logic   cmd_vld;
  logic   cmd_rdy;
  logic   sclk;
  logic   cs;
  logic   mosi;
  logic   miso;
  logic   read_vld;
  rdata_t read_data;

  rdata_t ref_regs [8];
  cmd_t   exp_cmd [$];  // accepted commands in push order.
  rdata_t exp_data [$]; // write data or expected read data.
  int     seed = 84597;
  int     errors = 0;
  int     checks = 0;
  int     accepted = 0;
  int     intervals = 0;
  int     cycles = 0;
  int     low_cycles = 0;
  int     high_cycles = 0;
  int     rises = 0;
  logic   cs_q = 1'b1;
  logic   sclk_q = 1'b0;
  logic   rdy_low_seen = 1'b0;

  spi_cmd_top spi_cmd_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_inst (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the command stream never drained", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input int exp_val, input int act_val);
    checks++;
    assert (exp_val == act_val)
    else
    begin
      errors++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp_val, act_val);
    end
  endtask

  // a read sends zeros on mosi once its header bits are out.
  function automatic logic expected_mosi(input cmd_t c, input int n);
    if (n >= `SPI_CMD_W || (!c[`SPI_CMD_W-1] && n >= `SPI_CMD_W - `SPI_READ_W))
      return 1'b0;
    else
      return c[`SPI_CMD_W-1-n];
  endfunction

  // called on a falling clk edge, returns on the next one.
  task automatic push_cmd(input cmd_t c);
    while (!cmd_rdy)
    begin
      cmd_vld = 1'b0;
      @(negedge clk);
    end
    cmd_in  = c;
    cmd_vld = 1'b1;
    accepted++;
    exp_cmd.push_back(c);
    if (c[11])
    begin
      ref_regs[c[10:8]] = c[7:0];
      exp_data.push_back(c[7:0]);
    end
    else
    begin
      exp_data.push_back(ref_regs[c[10:8]]);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] addr, input rdata_t data);
    push_cmd({1'b1, addr, data});
  endtask

  task automatic read_reg(input logic [2:0] addr);
    push_cmd({1'b0, addr, 8'h00});
  endtask

  task automatic wait_idle();
    while (exp_cmd.size() != 0 || !cs)
      @(negedge clk);
  endtask

  a_sclk_only_selected: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
  else
  begin
    errors++;
    $display("sclk is high while cs is high at %0t", $time);
  end

  a_push_ready: assert property (@(posedge clk) disable iff (!rst_n) cmd_vld |-> cmd_rdy)
  else
  begin
    errors++;
    $display("command pushed while cmd_rdy was low at %0t", $time);
  end

  always @(negedge clk)
  begin : monitor
    cmd_t   c;
    rdata_t d;
    if (rst_n)
    begin
      if (!cmd_rdy)
        rdy_low_seen = 1'b1;
      if (!cs)
      begin
        if (cs_q)
        begin
          if (intervals > 0 && high_cycles < GAP_CYCLES)
          begin
            errors++;
            $display("cs gap of %0d cycles is too short at %0t", high_cycles, $time);
          end
          low_cycles = 0;
          rises      = 0;
        end
        low_cycles++;
        if (sclk && !sclk_q)
        begin
          if (exp_cmd.size() != 0)
            check_value("mosi", expected_mosi(exp_cmd[0], rises), mosi);
          rises++;
        end
        check_value("read_vld", 0, read_vld);
      end
      else if (!cs_q)
      begin
        // end of a transfer.
        intervals++;
        high_cycles = 1;
        check_value("sclk rises", 12, rises);
        check_value("cs low cycles", XFER_CYCLES, low_cycles);
        if (exp_cmd.size() == 0)
        begin
          errors++;
          $display("cs rose at %0t with no command outstanding", $time);
        end
        else
        begin
          c = exp_cmd.pop_front();
          d = exp_data.pop_front();
          if (c[11])
          begin
            check_value("read_vld", 0, read_vld);
            check_value("slave regs", d, slave_inst.regs[c[10:8]]);
          end
          else
          begin
            check_value("read_vld", 1, read_vld);
            check_value("read_data", d, read_data);
          end
        end
      end
      else
      begin
        high_cycles++;
        check_value("read_vld", 0, read_vld);
      end
      cs_q   = cs;
      sclk_q = sclk;
    end
  end

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'h3c ^ (8'(i) * 8'h25);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("cs", 1, cs);
    check_value("sclk", 0, sclk);
    check_value("read_vld", 0, read_vld);
    check_value("cmd_rdy", 1, cmd_rdy);
    repeat (3) @(negedge clk);

    for (int i = 0; i < 8; i++)
      write_reg(3'(i), 8'($random(seed)));
    for (int i = 0; i < 8; i++)
      read_reg(3'(i));
    wait_idle();

    // burst into the queue while a transfer is on the wire.
    write_reg(3'd2, 8'($random(seed)));
    while (cs)
      @(negedge clk);
    read_reg(3'd2);
    write_reg(3'd5, 8'($random(seed)));
    read_reg(3'd5);
    write_reg(3'd7, 8'($random(seed)));
    read_reg(3'd7);
    wait_idle();

    for (int n = 0; n < 16; n++)
      push_cmd(cmd_t'($random(seed)));
    wait_idle();
    repeat (4) @(negedge clk);

    check_value("cs-low intervals", accepted, intervals);
    assert (rdy_low_seen)
    else
    begin
      errors++;
      $display("cmd_rdy never dropped while the queue was filled");
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: spi_cmd.f
+incdir+.
spi_cmd_pkg.sv
spi_cmd_fifo.sv
spi_sclk_gen.sv
spi_xfer_ctrl.sv
spi_cmd_top.sv
spi_slave_model.sv
tb_spi_cmd_top.sv
